/* filelist.f */
+incdir+tb
source/usb_mon_pkg.sv
source/usb_mon_ctrl.sv
source/usb_pkt_store.sv
source/usb_mon_egress.sv
source/usb_mon_regs.sv
source/usb_monitor.sv
tb/tb_usb_monitor.sv

/* run.sh */
#!/bin/sh
# Verilator build and run; the result is judged from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary --timing -Wno-fatal --top-module tb_usb_monitor \
        -f filelist.f -o tb_usb_monitor \
    && { ./obj_dir/tb_usb_monitor > sim.log 2>&1 || true; } \
    && grep -qF '** PASS **' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* source/usb_mon_ctrl.sv */
// Proxy FSM. Only one packet is in flight, and a sop from the other side meanwhile is ignored
// Packets longer than PKT_DEPTH are dropped whole during store-and-forward
`timescale 1ns/100ps

module usb_mon_ctrl #(
    parameter int PKT_DEPTH = usb_mon_pkg::PKT_DEPTH,
    parameter int PKT_AW    = usb_mon_pkg::PKT_AW
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_mon_pkg::usb_rx_t     host_rx,
    input  usb_mon_pkg::usb_rx_t     dev_rx,
    input  usb_mon_pkg::mon_cfg_t    cfg,
    input  logic [63:0]              timestamp,
    output usb_mon_pkg::egress_cmd_t cmd,
    output logic                     st_we,
    output logic [PKT_AW-1:0]        st_waddr,
    output logic [7:0]               st_wdata,
    output logic [PKT_AW-1:0]        st_raddr,
    output logic                     st_xlate_req,
    input  logic                     st_xlate_hit,
    output usb_mon_pkg::mon_evt_t    evt
);
    import usb_mon_pkg::*;

    localparam int CNT_W = PKT_AW + 1;      // One extra bit to see overflow

    ctrl_state_e       state_q;
    usb_dir_e          dir_q;
    usb_pid_e          pid_q;
    logic [63:0]       ts_q;
    logic [CNT_W-1:0]  cnt_q;               // Byte index in the packet
    logic [PKT_AW-1:0] len_q;               // Index of the last stored byte
    logic              mod_q;

    logic     host_go;
    logic     dev_go;
    logic     start;
    logic     in_idle;
    logic     pass_pkt;
    logic     cnt_full;
    usb_rx_t  rx;
    usb_dir_e dir_cur;

    ////////////////////////////////////////////////////////////
    // Stream select and commands
    ////////////////////////////////////////////////////////////
    always_comb begin
        host_go  = cfg.proxy_en && host_rx.valid && host_rx.sop;  // Host wins in idle
        dev_go   = cfg.proxy_en && dev_rx.valid && dev_rx.sop && !host_go;
        start    = host_go || dev_go;
        in_idle  = (state_q == ST_IDLE);
        dir_cur  = in_idle ? (dev_go ? DIR_D2H : DIR_H2D) : dir_q;
        rx       = (dir_cur == DIR_D2H) ? dev_rx : host_rx;
        pass_pkt = (rx.pid == PID_SOF) || !cfg.store_en;
        cnt_full = (cnt_q == CNT_W'(PKT_DEPTH));

        cmd          = '0;
        cmd.dir      = dir_cur;
        cmd.pid      = in_idle ? rx.pid : pid_q;
        cmd.data     = rx.data;
        cmd.ts       = in_idle ? timestamp : ts_q;
        st_we        = 1'b0;
        st_xlate_req = 1'b0;
        evt          = '0;
        evt.data     = rx.data;
        evt.crc_err  = (host_rx.valid && host_rx.eop && !host_rx.crc_ok) ||
                       (dev_rx.valid && dev_rx.eop && !dev_rx.crc_ok);

        case (state_q)
            ST_IDLE: begin
                cmd.valid = start && pass_pkt;      // The sop byte itself goes out
                cmd.sop   = rx.sop;
                cmd.eop   = rx.eop;
                st_we     = start && !pass_pkt;
            end
            ST_PASS: begin
                cmd.valid       = rx.valid;
                cmd.sop         = rx.sop;
                cmd.eop         = rx.eop;
                evt.frame_lo_we = rx.valid && (pid_q == PID_SOF) && (cnt_q == CNT_W'(1));
                evt.frame_hi_we = rx.valid && (pid_q == PID_SOF) && (cnt_q == CNT_W'(2));
            end
            ST_STORE: begin
                st_we        = rx.valid && !cnt_full;
                evt.overflow = rx.valid && cnt_full;
            end
            ST_XLATE: st_xlate_req = 1'b1;
            ST_REPLAY: begin
                cmd.valid    = 1'b1;
                cmd.replay   = 1'b1;
                cmd.sop      = (cnt_q == '0);
                cmd.eop      = (cnt_q[PKT_AW-1:0] == len_q);
                cmd.modified = mod_q || st_xlate_hit;   // Hit lands on the first byte
            end
            default: ;
        endcase
    end

    assign st_waddr = in_idle ? '0 : cnt_q[PKT_AW-1:0];
    assign st_wdata = rx.data;
    assign st_raddr = cnt_q[PKT_AW-1:0];

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            dir_q   <= DIR_H2D;
            pid_q   <= PID_OUT;
            ts_q    <= '0;
            cnt_q   <= '0;
            len_q   <= '0;
            mod_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    mod_q <= 1'b0;
                    cnt_q <= CNT_W'(1);
                    if (start) begin
                        dir_q <= dir_cur;
                        pid_q <= rx.pid;
                        ts_q  <= timestamp;
                        len_q <= '0;
                        if (!rx.eop) begin
                            state_q <= pass_pkt ? ST_PASS : ST_STORE;
                        end else if (!pass_pkt) begin
                            state_q <= ST_XLATE;    // Single-byte packet
                        end
                    end
                end
                ST_PASS: begin
                    if (rx.valid) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (rx.eop) state_q <= ST_IDLE;
                    end
                end
                ST_STORE: begin
                    if (rx.valid && cnt_full) begin
                        state_q <= rx.eop ? ST_IDLE : ST_DRAIN;
                    end else if (rx.valid) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (rx.eop) begin
                            len_q   <= cnt_q[PKT_AW-1:0];
                            state_q <= ST_XLATE;
                        end
                    end
                end
                ST_XLATE: begin
                    cnt_q   <= '0;
                    state_q <= ST_REPLAY;
                end
                ST_REPLAY: begin
                    mod_q <= mod_q || st_xlate_hit;
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q[PKT_AW-1:0] == len_q) state_q <= ST_IDLE;
                end
                ST_DRAIN: begin
                    if (rx.valid && rx.eop) state_q <= ST_IDLE;   // Drop rest of the packet
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

/* source/usb_mon_egress.sv */
// Output stage for both tx sides and the lossy capture port
// A byte not taken by cap_ready in its cycle is lost and counted
`timescale 1ns/100ps

module usb_mon_egress (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_mon_pkg::egress_cmd_t cmd,
    input  logic [7:0]               rdata,
    input  logic                     cap_ready,
    output usb_mon_pkg::usb_tx_t     dev_tx,
    output usb_mon_pkg::usb_tx_t     host_tx,
    output usb_mon_pkg::cap_rec_t    cap,
    output logic                     cap_valid,
    output logic [15:0]              cap_drop_cnt
);
    import usb_mon_pkg::*;

    egress_cmd_t cmd_q;         // Payload, replay data is still in the RAM read
    logic        vld_q;
    logic        to_dev;
    logic [7:0]  out_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= cmd.valid;
        end
    end

    always_ff @(posedge clk) begin
        cmd_q <= cmd;
    end

    assign to_dev   = (cmd_q.dir == DIR_H2D);
    assign out_data = cmd_q.replay ? rdata : cmd_q.data;   // RAM read lines up here

    always_comb begin
        dev_tx.data  = out_data;
        dev_tx.valid = vld_q && to_dev;
        dev_tx.sop   = vld_q && to_dev && cmd_q.sop;
        dev_tx.eop   = vld_q && to_dev && cmd_q.eop;
        dev_tx.pid   = cmd_q.pid;

        host_tx.data  = out_data;
        host_tx.valid = vld_q && !to_dev;
        host_tx.sop   = vld_q && !to_dev && cmd_q.sop;
        host_tx.eop   = vld_q && !to_dev && cmd_q.eop;
        host_tx.pid   = cmd_q.pid;
    end

    ////////////////////////////////////////////////////////////
    // Capture record
    ////////////////////////////////////////////////////////////
    assign cap_valid          = vld_q;
    assign cap.data           = out_data;
    assign cap.flags.modified = cmd_q.modified;
    assign cap.flags.pid      = cmd_q.pid;
    assign cap.flags.dir      = cmd_q.dir;
    assign cap.ts             = cmd_q.ts;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_drop_cnt <= '0;
        end else if (vld_q && !cap_ready) begin
            cap_drop_cnt <= cap_drop_cnt + 1'b1;    // Wraps at 16 bits
        end
    end

endmodule

/* source/usb_mon_pkg.sv */
// Shared types, register map and defaults for the USB monitor
// PIDs use the 4-bit USB 2.0 encoding without the check nibble
package usb_mon_pkg;

    ////////////////////////////////////////////////////////////
    // Defaults and register map
    ////////////////////////////////////////////////////////////
    localparam int PKT_DEPTH  = 64;                 // Packet store size in bytes
    localparam int PKT_AW     = $clog2(PKT_DEPTH);
    localparam int REG_ADDR_W = 8;

    localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [REG_ADDR_W-1:0] REG_XLATE    = 8'h04;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS   = 8'h08;
    localparam logic [REG_ADDR_W-1:0] REG_ERR_CNT  = 8'h0C;
    localparam logic [REG_ADDR_W-1:0] REG_FRAME    = 8'h10;
    localparam logic [REG_ADDR_W-1:0] REG_CAP_DROP = 8'h14;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_DATA2 = 4'b0111,
        PID_MDATA = 4'b1111,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110,
        PID_NYET  = 4'b0110,
        PID_SOF   = 4'b0101
    } usb_pid_e;

    typedef enum logic {
        DIR_H2D = 1'b0,     // Host to device
        DIR_D2H = 1'b1
    } usb_dir_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PASS,
        ST_STORE,
        ST_XLATE,
        ST_REPLAY,
        ST_DRAIN
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sop;        // Only meaningful with valid
        logic       eop;
        usb_pid_e   pid;
        logic       crc_ok;
    } usb_rx_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sop;
        logic       eop;
        usb_pid_e   pid;
    } usb_tx_t;

    typedef struct packed {
        logic     modified;
        usb_pid_e pid;
        usb_dir_e dir;
    } cap_flags_t;

    typedef struct packed {
        logic [7:0]  data;
        cap_flags_t  flags;
        logic [63:0] ts;        // Arrival time of the packet's sop
    } cap_rec_t;

    typedef struct packed {
        logic        valid;
        logic        replay;    // Data comes from the packet store
        usb_dir_e    dir;
        logic        sop;
        logic        eop;
        usb_pid_e    pid;
        logic        modified;
        logic [7:0]  data;
        logic [63:0] ts;
    } egress_cmd_t;

    typedef struct packed {
        logic       crc_err;
        logic       overflow;
        logic       frame_lo_we;
        logic       frame_hi_we;
        logic [7:0] data;
    } mon_evt_t;

    typedef struct packed {
        logic       proxy_en;
        logic       store_en;
        logic       xlate_en;
        logic [6:0] xlate_from;
        logic [6:0] xlate_to;
    } mon_cfg_t;

endpackage

/* source/usb_mon_regs.sv */
// APB slave with zero wait states; unlisted read addresses return pslverr
// Writes to read-only registers are ignored
`timescale 1ns/100ps

module usb_mon_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [usb_mon_pkg::REG_ADDR_W-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  usb_mon_pkg::mon_evt_t             evt,
    input  logic [15:0]                       cap_drop_cnt,
    input  logic                              event_valid,
    input  logic [7:0]                        event_type,
    output usb_mon_pkg::mon_cfg_t             cfg
);
    import usb_mon_pkg::*;

    logic        crc_sticky_q;
    logic [1:0]  speed_q;
    logic [15:0] err_cnt_q;
    logic [15:0] frame_q;
    logic        wr_en;
    logic        addr_ok;

    assign pready = 1'b1;
    assign wr_en  = psel && penable && pwrite;     // Takes effect in the access phase

    ////////////////////////////////////////////////////////////
    // Configuration and status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg          <= '0;         // Proxy off
            crc_sticky_q <= 1'b0;
            speed_q      <= 2'b00;
            err_cnt_q    <= '0;
            frame_q      <= '0;
        end else begin
            if (wr_en && paddr == REG_CTRL) begin
                cfg.proxy_en <= pwdata[0];
                cfg.store_en <= pwdata[1];
                cfg.xlate_en <= pwdata[2];
            end
            if (wr_en && paddr == REG_XLATE) begin
                cfg.xlate_from <= pwdata[6:0];
                cfg.xlate_to   <= pwdata[14:8];
            end
            if (evt.crc_err) crc_sticky_q <= 1'b1;
            err_cnt_q <= err_cnt_q + 16'(evt.crc_err) + 16'(evt.overflow);
            if (evt.frame_lo_we) frame_q[7:0]  <= evt.data;
            if (evt.frame_hi_we) frame_q[15:8] <= evt.data;
            if (event_valid) begin
                case (event_type)
                    8'h01:   speed_q <= 2'b01;  // Full speed
                    8'h02:   speed_q <= 2'b10;  // High speed
                    8'h03:   speed_q <= 2'b00;  // Low speed
                    default: ;
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        prdata  = '0;
        addr_ok = 1'b1;
        case (paddr)
            REG_CTRL:     prdata = {29'd0, cfg.xlate_en, cfg.store_en, cfg.proxy_en};
            REG_XLATE:    prdata = {17'd0, cfg.xlate_to, 1'b0, cfg.xlate_from};
            REG_STATUS:   prdata = {29'd0, speed_q, crc_sticky_q};
            REG_ERR_CNT:  prdata = {16'd0, err_cnt_q};
            REG_FRAME:    prdata = {16'd0, frame_q};
            REG_CAP_DROP: prdata = {16'd0, cap_drop_cnt};
            default:      addr_ok = 1'b0;
        endcase
    end

    assign pslverr = psel && penable && !pwrite && !addr_ok;

endmodule

/* source/usb_monitor.sv */
// USB monitor and proxy top, single clock domain
// Configuration is all zero after reset, so nothing is forwarded until CTRL is written
`timescale 1ns/100ps

module usb_monitor #(
    parameter int PKT_DEPTH = usb_mon_pkg::PKT_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  usb_mon_pkg::usb_rx_t              host_rx,
    input  usb_mon_pkg::usb_rx_t              dev_rx,
    output usb_mon_pkg::usb_tx_t              dev_tx,
    output usb_mon_pkg::usb_tx_t              host_tx,
    output usb_mon_pkg::cap_rec_t             cap,
    output logic                              cap_valid,
    input  logic                              cap_ready,
    input  logic [63:0]                       timestamp,
    input  logic                              event_valid,
    input  logic [7:0]                        event_type,
    input  logic [usb_mon_pkg::REG_ADDR_W-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import usb_mon_pkg::*;

    localparam int AW = $clog2(PKT_DEPTH);

    egress_cmd_t cmd;
    mon_evt_t    evt;
    mon_cfg_t    cfg;
    logic          st_we;
    logic [AW-1:0] st_waddr;
    logic [7:0]    st_wdata;
    logic [AW-1:0] st_raddr;
    logic          st_xlate_req;
    logic          st_xlate_hit;
    logic [7:0]    st_rdata;
    logic [15:0]   cap_drop_cnt;

    usb_mon_ctrl #(.PKT_DEPTH(PKT_DEPTH), .PKT_AW(AW)) u_ctrl (
        .clk, .rst_n, .host_rx, .dev_rx, .cfg, .timestamp, .cmd,
        .st_we, .st_waddr, .st_wdata, .st_raddr, .st_xlate_req, .st_xlate_hit, .evt
    );

    // PID for the rewrite check rides on the command bus
    usb_pkt_store #(.PKT_DEPTH(PKT_DEPTH), .PKT_AW(AW)) u_store (
        .clk, .we(st_we), .waddr(st_waddr), .wdata(st_wdata), .raddr(st_raddr),
        .xlate_req(st_xlate_req), .cfg, .pid(cmd.pid),
        .rdata(st_rdata), .xlate_hit(st_xlate_hit)
    );

    usb_mon_egress u_egress (
        .clk, .rst_n, .cmd, .rdata(st_rdata), .cap_ready,
        .dev_tx, .host_tx, .cap, .cap_valid, .cap_drop_cnt
    );

    usb_mon_regs u_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .evt, .cap_drop_cnt, .event_valid, .event_type, .cfg
    );

endmodule

/* source/usb_pkt_store.sv */
// Packet RAM, one write port and a registered read port
// Rewrite only touches byte 1 and needs that byte written in the current packet
`timescale 1ns/100ps

module usb_pkt_store #(
    parameter int PKT_DEPTH = usb_mon_pkg::PKT_DEPTH,
    parameter int PKT_AW    = usb_mon_pkg::PKT_AW
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [PKT_AW-1:0]     waddr,
    input  logic [7:0]            wdata,
    input  logic [PKT_AW-1:0]     raddr,
    input  logic                  xlate_req,
    input  usb_mon_pkg::mon_cfg_t cfg,
    input  usb_mon_pkg::usb_pid_e pid,
    output logic [7:0]            rdata,
    output logic                  xlate_hit
);
    import usb_mon_pkg::*;

    logic [7:0] mem [PKT_DEPTH];

    logic [7:0]        byte1_q;     // Copy of byte 1, the token address
    logic              byte1_vld_q;
    logic              is_token;
    logic              match;
    logic              rewrite;
    logic              mem_we;
    logic [PKT_AW-1:0] mem_wa;
    logic [7:0]        mem_wd;

    assign is_token = (pid == PID_IN) || (pid == PID_OUT) || (pid == PID_SETUP);
    assign match    = cfg.xlate_en && is_token && byte1_vld_q &&
                      (byte1_q[6:0] == cfg.xlate_from);
    assign rewrite  = xlate_req && match;

    // Rewrite shares the write port, ctrl never stores during the check
    assign mem_we = we || rewrite;
    assign mem_wa = rewrite ? PKT_AW'(1) : waddr;
    assign mem_wd = rewrite ? {byte1_q[7], cfg.xlate_to} : wdata;   // Bit 7 kept

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_wa] <= mem_wd;
        rdata <= mem[raddr];
    end

    always_ff @(posedge clk) begin
        if (we && waddr == '0) begin
            byte1_vld_q <= 1'b0;        // New packet
        end else if (we && waddr == PKT_AW'(1)) begin
            byte1_q     <= wdata;
            byte1_vld_q <= 1'b1;
        end
        xlate_hit <= rewrite;
    end

endmodule

/* tb/usb_mon_tb_model.svh */
// Reference model of the forwarding rules and typed compare tasks
// Needs TB_DEPTH and abort_run from the including testbench module
`ifndef USB_MON_TB_MODEL_SVH
`define USB_MON_TB_MODEL_SVH

typedef logic [7:0] byte_q_t[$];
typedef usb_tx_t    tx_q_t[$];

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// True when a stored token has its address rewritten
function automatic logic expect_rewrite(byte_q_t pkt, usb_pid_e pid, mon_cfg_t c);
    logic token;
    token = (pid == PID_IN) || (pid == PID_OUT) || (pid == PID_SETUP);
    return c.proxy_en && c.store_en && c.xlate_en && token && (pkt.size() > 1) &&
           (pkt.size() <= TB_DEPTH) && (pkt[1][6:0] == c.xlate_from);
endfunction

function automatic tx_q_t expected_bytes(byte_q_t pkt, usb_pid_e pid, mon_cfg_t c);
    tx_q_t   res;
    usb_tx_t b;
    logic    stored;
    logic    hit;
    stored = c.store_en && (pid != PID_SOF);    // SOF always passes through
    hit    = expect_rewrite(pkt, pid, c);
    if (!c.proxy_en || (stored && pkt.size() > TB_DEPTH)) begin
        return res;                             // Proxy off or packet dropped
    end
    for (int i = 0; i < pkt.size(); i++) begin
        b.data  = (hit && i == 1) ? {pkt[1][7], c.xlate_to} : pkt[i];
        b.valid = 1'b1;
        b.sop   = (i == 0);
        b.eop   = (i == pkt.size() - 1);
        b.pid   = pid;
        res.push_back(b);
    end
    return res;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////
task automatic check_tx(string name, usb_tx_t exp, usb_tx_t act);
    if (act !== exp) begin
        abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
endtask

task automatic check_cap(string name, cap_rec_t exp, cap_rec_t act);
    if (act !== exp) begin
        abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
endtask

task automatic check_reg(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
        abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
endtask

`endif

/* tb/tb_usb_monitor.sv */
// Directed test of the USB monitor at the default packet store depth
// Payload bytes are random with a fixed seed, the run stops at the first error
`timescale 1ns/100ps

module tb_usb_monitor;
    import usb_mon_pkg::*;

    localparam int TB_DEPTH       = 64;
    localparam int TIMEOUT_CYCLES = 3000;   // Well above the length of the whole test

    logic                  clk;
    logic                  rst_n;
    usb_rx_t               host_rx;
    usb_rx_t               dev_rx;
    usb_tx_t               dev_tx;
    usb_tx_t               host_tx;
    cap_rec_t              cap;
    logic                  cap_valid;
    logic                  cap_ready;
    logic [63:0]           timestamp;
    logic                  event_valid;
    logic [7:0]            event_type;
    logic [REG_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    `include "usb_mon_tb_model.svh"

    mon_cfg_t    cfg_model;
    usb_tx_t     exp_dev[$];
    usb_tx_t     exp_host[$];
    cap_rec_t    exp_cap[$];
    usb_tx_t     tx_exp;
    cap_rec_t    cap_exp;
    byte_q_t     pkt;
    integer      seed;
    int          cycle_cnt = 0;
    logic [15:0] exp_err;
    logic [15:0] exp_drop;
    logic [31:0] rd_data;
    logic        rd_err;

    usb_monitor #(.PKT_DEPTH(TB_DEPTH)) u_usb_monitor (.*);

    always #5 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    // Every stimulus change happens 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
        timestamp = timestamp + 64'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////
    task automatic apb_write(logic [REG_ADDR_W-1:0] addr, logic [31:0] data);
        paddr  = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel   = 1'b1;
        tick();
        penable = 1'b1;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(logic [REG_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        tick();
        penable = 1'b1;
        @(negedge clk);         // Zero wait states so data is valid in the access phase
        data = prdata;
        err  = pslverr;
        check_reg("pready", 32'd1, {31'd0, pready});
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(logic [REG_ADDR_W-1:0] addr, string name, logic [31:0] exp);
        apb_read(addr, rd_data, rd_err);
        check_reg(name, exp, rd_data);
        check_reg({name, " pslverr"}, 32'd0, {31'd0, rd_err});
    endtask

    task automatic set_cfg(logic proxy, logic store, logic xlate, logic [6:0] from,
                           logic [6:0] to);
        cfg_model.proxy_en   = proxy;
        cfg_model.store_en   = store;
        cfg_model.xlate_en   = xlate;
        cfg_model.xlate_from = from;
        cfg_model.xlate_to   = to;
        apb_write(REG_XLATE, {17'd0, to, 1'b0, from});
        apb_write(REG_CTRL, {29'd0, xlate, store, proxy});
    endtask

    ////////////////////////////////////////////////////////////
    // Packet stimulus
    ////////////////////////////////////////////////////////////
    function automatic byte_q_t make_packet(usb_pid_e pid, int len);
        byte_q_t q;
        q.push_back({~pid, pid});               // PID byte with check nibble
        for (int i = 1; i < len; i++) q.push_back(8'($random(seed)));
        return q;
    endfunction

    // Token with bit 7 of byte 1 set, so the rewrite must keep it
    function automatic byte_q_t make_token(usb_pid_e pid, logic [6:0] addr);
        byte_q_t q;
        q.push_back({~pid, pid});
        q.push_back({1'b1, addr});
        q.push_back(8'($random(seed)));
        return q;
    endfunction

    task automatic send_packet(usb_dir_e dir, usb_pid_e pid, byte_q_t data, logic bad_crc);
        tx_q_t    exp;
        cap_rec_t c;
        usb_rx_t  b;
        logic     mod;
        exp = expected_bytes(data, pid, cfg_model);
        mod = expect_rewrite(data, pid, cfg_model);
        foreach (exp[i]) begin
            if (dir == DIR_H2D) exp_dev.push_back(exp[i]);
            else exp_host.push_back(exp[i]);
            c.data           = exp[i].data;
            c.flags.modified = mod;
            c.flags.pid      = pid;
            c.flags.dir      = dir;
            c.ts             = timestamp;       // Value seen with the sop byte
            exp_cap.push_back(c);
        end
        for (int i = 0; i < data.size(); i++) begin
            b.data   = data[i];
            b.valid  = 1'b1;
            b.sop    = (i == 0);
            b.eop    = (i == data.size() - 1);
            b.pid    = pid;
            b.crc_ok = !(bad_crc && b.eop);
            if (dir == DIR_H2D) host_rx = b;
            else dev_rx = b;
            tick();
        end
        host_rx = '0;
        dev_rx  = '0;
        while (exp_dev.size() != 0 || exp_host.size() != 0 || exp_cap.size() != 0) tick();
        repeat (2) tick();
    endtask

    ////////////////////////////////////////////////////////////
    // Output checking, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (dev_tx.valid) begin
                if (exp_dev.size() == 0) abort_run("Unexpected byte on dev_tx");
                tx_exp = exp_dev.pop_front();
                check_tx("dev_tx", tx_exp, dev_tx);
            end
            if (host_tx.valid) begin
                if (exp_host.size() == 0) abort_run("Unexpected byte on host_tx");
                tx_exp = exp_host.pop_front();
                check_tx("host_tx", tx_exp, host_tx);
            end
            if (cap_valid) begin
                if (exp_cap.size() == 0) abort_run("Unexpected capture record");
                cap_exp = exp_cap.pop_front();
                if (cap_ready) check_cap("cap", cap_exp, cap);   // Else lost
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, test did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        host_rx     = '0;
        dev_rx      = '0;
        cap_ready   = 1'b1;
        timestamp   = 64'h0000_0100_0000_0000;
        event_valid = 1'b0;
        event_type  = 8'h00;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        seed        = 32'h3;
        cfg_model   = '0;
        exp_err     = '0;
        exp_drop    = '0;
        repeat (3) tick();
        rst_n = 1'b1;
        tick();

        // Register access and the error response
        read_check(REG_CTRL, "CTRL", 32'h0);
        set_cfg(1'b1, 1'b0, 1'b0, 7'h15, 7'h2A);
        read_check(REG_CTRL, "CTRL", 32'h1);
        read_check(REG_XLATE, "XLATE", 32'h0000_2A15);
        apb_read(8'h20, rd_data, rd_err);
        check_reg("pslverr", 32'd1, {31'd0, rd_err});
        check_reg("prdata", 32'd0, rd_data);

        // Pass-through in both directions
        pkt = make_token(PID_OUT, 7'h15);
        send_packet(DIR_H2D, PID_OUT, pkt, 1'b0);
        pkt = make_packet(PID_DATA0, 8);
        send_packet(DIR_D2H, PID_DATA0, pkt, 1'b0);

        // Store-and-forward with address rewrite
        set_cfg(1'b1, 1'b1, 1'b1, 7'h15, 7'h2A);
        read_check(REG_CTRL, "CTRL", 32'h7);
        pkt = make_token(PID_OUT, 7'h15);
        send_packet(DIR_H2D, PID_OUT, pkt, 1'b0);
        pkt = make_token(PID_OUT, 7'h33);
        send_packet(DIR_H2D, PID_OUT, pkt, 1'b0);
        pkt = make_packet(PID_DATA1, 10);
        send_packet(DIR_D2H, PID_DATA1, pkt, 1'b0);

        // Store overflow
        set_cfg(1'b1, 1'b1, 1'b0, 7'h15, 7'h2A);
        pkt = make_packet(PID_DATA1, TB_DEPTH + 4);
        send_packet(DIR_H2D, PID_DATA1, pkt, 1'b0);
        exp_err = exp_err + 16'd1;
        read_check(REG_ERR_CNT, "ERR_CNT", {16'd0, exp_err});

        // CRC error, frame number and speed
        set_cfg(1'b1, 1'b0, 1'b0, 7'h15, 7'h2A);
        pkt = make_packet(PID_DATA0, 5);
        send_packet(DIR_H2D, PID_DATA0, pkt, 1'b1);
        exp_err = exp_err + 16'd1;
        read_check(REG_ERR_CNT, "ERR_CNT", {16'd0, exp_err});
        pkt = make_packet(PID_SOF, 3);
        send_packet(DIR_H2D, PID_SOF, pkt, 1'b0);
        read_check(REG_FRAME, "FRAME", {16'd0, pkt[2], pkt[1]});
        event_valid = 1'b1;
        event_type  = 8'h02;
        tick();
        event_valid = 1'b0;
        event_type  = 8'h00;
        read_check(REG_STATUS, "STATUS", 32'h0000_0005);   // High speed, sticky CRC

        // Capture port stalled for a whole packet
        cap_ready = 1'b0;
        pkt = make_packet(PID_DATA1, 6);
        send_packet(DIR_D2H, PID_DATA1, pkt, 1'b0);
        cap_ready = 1'b1;
        exp_drop  = exp_drop + 16'(pkt.size());
        read_check(REG_CAP_DROP, "CAP_DROP", {16'd0, exp_drop});

        if (exp_dev.size() != 0 || exp_host.size() != 0 || exp_cap.size() != 0) begin
            abort_run("Expected output bytes were never seen");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
